//--- design/icache_pkg.sv
package icache_pkg;

    localparam int WORD_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int WAYS       = 4;
    localparam int SETS       = 128;
    localparam int LINE_WORDS = 8;
    localparam int TAG_W      = 20;
    localparam int INDEX_W    = 7;
    localparam int OFFSET_W   = 5;
    localparam int WAY_W      = 2;
    localparam int BEAT_W     = 3;

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [WAY_W-1:0]   way_t;
    typedef logic [BEAT_W-1:0]  beat_t;

    // one bit per way, one-hot on a hit
    typedef logic [WAYS-1:0] way_mask_t;

    // normal fetch address, word select is offset[4:2]
    typedef struct packed {
        tag_t                tag;
        index_t              index;
        logic [OFFSET_W-1:0] offset;
    } fetch_addr_t;

    // index-type cache op, way taken from bits 13:12
    typedef struct packed {
        logic [ADDR_W-WAY_W-INDEX_W-OFFSET_W-1:0] upper;
        way_t                                     way;
        index_t                                   index;
        logic [OFFSET_W-1:0]                      offset;
    } op_addr_t;

    typedef union packed {
        fetch_addr_t fetch;
        op_addr_t    op;
    } icache_addr_u;

    typedef enum logic [1:0] {
        OP_INDEX_INV = 2'd0,
        OP_HIT_INV   = 2'd1
    } cache_op_kind_e;

    typedef struct packed {
        cache_op_kind_e kind;
        icache_addr_u   addr;
    } cache_op_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } axi_r_t;

endpackage

//--- design/icache_tag_array.sv
`timescale 1ns/1ps

module icache_tag_array
    import icache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  index_t    index,
    input  tag_t      lookup_tag,
    input  logic      wr_en,
    input  way_t      wr_way,
    input  tag_t      wr_tag,
    input  logic      inv_en,
    input  way_t      inv_way,
    output way_mask_t hit
);

    tag_t                      tag_mem [WAYS][SETS];
    logic [SETS-1:0][WAYS-1:0] valid;

    tag_t      tag_q [WAYS];
    way_mask_t valid_q;

    // tag storage with a synchronous read of all ways
    always_ff @(posedge clk)
    begin
        for (int w = 0; w < WAYS; w++)
        begin
            tag_q[w] <= tag_mem[w][index];
        end
        if (wr_en)
        begin
            tag_mem[wr_way][index] <= wr_tag;
        end
    end

    // valid flops and their registered read
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid   <= '0;
            valid_q <= '0;
        end
        else
        begin
            valid_q <= valid[index];
            if (wr_en)
            begin
                valid[index][wr_way] <= 1'b1;
            end
            if (inv_en)
            begin
                valid[index][inv_way] <= 1'b0;
            end
        end
    end

    always_comb
    begin
        for (int w = 0; w < WAYS; w++)
        begin
            hit[w] = valid_q[w] && (tag_q[w] == lookup_tag);
        end
    end

endmodule

//--- design/icache_data_array.sv
`timescale 1ns/1ps

module icache_data_array
    import icache_pkg::*;
(
    input  logic      clk,
    input  index_t    index,
    input  logic      wr_en,
    input  way_t      wr_way,
    input  beat_t     wr_beat,
    input  word_t     wr_data,
    input  way_mask_t hit,
    input  beat_t     word_sel,
    output word_t     rdata
);

    word_t [LINE_WORDS-1:0] line_mem [WAYS][SETS];
    word_t [LINE_WORDS-1:0] line_q [WAYS];

    // whole lines of every way are read, one word is written per beat
    always_ff @(posedge clk)
    begin
        for (int w = 0; w < WAYS; w++)
        begin
            line_q[w] <= line_mem[w][index];
        end
        if (wr_en)
        begin
            line_mem[wr_way][index][wr_beat] <= wr_data;
        end
    end

    // hit is one-hot, so an and-or mux is enough
    always_comb
    begin
        rdata = '0;
        for (int w = 0; w < WAYS; w++)
        begin
            if (hit[w])
            begin
                rdata = rdata | line_q[w][word_sel];
            end
        end
    end

endmodule

//--- design/icache_lru.sv
`timescale 1ns/1ps

module icache_lru
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  index_t index,
    input  logic   touch,
    input  way_t   touch_way,
    output way_t   victim
);

    // entry 0 is most recent, entry WAYS-1 is least recent
    way_t [WAYS-1:0] stack [SETS];

    index_t          read_index;
    way_t [WAYS-1:0] cur;
    way_t [WAYS-1:0] nxt;
    way_t            pos;

    assign victim = stack[index][WAYS-1];

    // a touch lands one cycle after its set was presented at index,
    // by then index may already point at the next fetch
    always_ff @(posedge clk)
    begin
        read_index <= index;
    end

    always_comb
    begin
        cur = stack[read_index];
        pos = way_t'(WAYS-1);
        for (int i = 0; i < WAYS; i++)
        begin
            if (cur[i] == touch_way)
            begin
                pos = way_t'(i);
            end
        end
        nxt[0] = touch_way;
        for (int i = 1; i < WAYS; i++)
        begin
            nxt[i] = (i <= int'(pos)) ? cur[i-1] : cur[i];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < SETS; s++)
            begin
                for (int i = 0; i < WAYS; i++)
                begin
                    stack[s][i] <= way_t'(i);
                end
            end
        end
        else if (touch)
        begin
            stack[read_index] <= nxt;
        end
    end

endmodule

//--- design/icache_refill.sv
`timescale 1ns/1ps

module icache_refill
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   refill_start,
    input  word_t  line_addr,
    output word_t  araddr,
    output logic   arvalid,
    input  logic   arready,
    input  axi_r_t r,
    input  logic   rvalid,
    output logic   rready,
    output logic   fill_en,
    output beat_t  fill_beat,
    output logic   refill_done
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_ADDR,
        R_DATA
    } refill_state_t;

    refill_state_t state;
    beat_t         beat;

    assign arvalid     = (state == R_ADDR);
    assign rready      = (state == R_DATA);
    assign fill_en     = rready && rvalid;
    assign fill_beat   = beat;
    assign refill_done = fill_en && r.last;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= R_IDLE;
            beat  <= '0;
        end
        else
        begin
            unique case (state)
                R_IDLE:
                begin
                    if (refill_start)
                    begin
                        state <= R_ADDR;
                        beat  <= '0;
                    end
                end
                R_ADDR:
                begin
                    if (arready)
                    begin
                        state <= R_DATA;
                    end
                end
                default:
                begin
                    if (fill_en)
                    begin
                        beat <= beat + 1'b1;
                        if (r.last)
                        begin
                            state <= R_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    // burst address held stable until arready
    always_ff @(posedge clk)
    begin
        if ((state == R_IDLE) && refill_start)
        begin
            araddr <= line_addr;
        end
    end

endmodule

//--- design/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl
    import icache_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         inst_req,
    input  icache_addr_u inst_addr,
    output logic         inst_addr_ok,
    output logic         inst_data_ok,
    input  logic         cache_req,
    input  cache_op_t    cache_op,
    output logic         cache_op_ok,
    input  way_mask_t    hit,
    input  way_t         victim,
    output index_t       index,
    output tag_t         lookup_tag,
    output beat_t        word_sel,
    output logic         tag_wr_en,
    output way_t         fill_way,
    output logic         inv_en,
    output way_t         inv_way,
    output logic         lru_touch,
    output way_t         lru_touch_way,
    output logic         refill_start,
    output word_t        line_addr,
    input  logic         refill_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_REFILL,
        S_REREAD,
        S_OP_INDEX,
        S_OP_HIT_READ,
        S_OP_HIT_CLEAR
    } ctrl_state_t;

    ctrl_state_t  state;
    icache_addr_u addr_q;
    way_mask_t    hit_q;
    logic         hit_any;
    logic         op_accept;

    function automatic way_t mask_to_way(way_mask_t m);
        way_t w;
        w = '0;
        for (int i = 0; i < WAYS; i++)
        begin
            if (m[i])
            begin
                w = way_t'(i);
            end
        end
        return w;
    endfunction

    assign hit_any   = |hit;
    assign op_accept = (state == S_IDLE) && cache_req;

    // a hit frees the lookup stage, so the next fetch can go in the same cycle
    assign inst_addr_ok = inst_req && !cache_req
                          && ((state == S_IDLE) || ((state == S_LOOKUP) && hit_any));
    assign inst_data_ok = (state == S_LOOKUP) && hit_any;
    assign cache_op_ok  = (state == S_OP_INDEX) || (state == S_OP_HIT_CLEAR);

    assign lookup_tag   = addr_q.fetch.tag;
    assign word_sel     = addr_q.fetch.offset[OFFSET_W-1:2];
    assign line_addr    = {addr_q.fetch.tag, addr_q.fetch.index, {OFFSET_W{1'b0}}};
    assign refill_start = (state == S_LOOKUP) && !hit_any;
    assign tag_wr_en    = (state == S_REFILL) && refill_done;

    assign lru_touch     = inst_data_ok;
    assign lru_touch_way = mask_to_way(hit);

    assign inv_en  = (state == S_OP_INDEX) || ((state == S_OP_HIT_CLEAR) && (|hit_q));
    assign inv_way = (state == S_OP_INDEX) ? addr_q.op.way : mask_to_way(hit_q);

    // incoming address on acceptance, otherwise the held one
    always_comb
    begin
        if (inst_addr_ok)
        begin
            index = inst_addr.fetch.index;
        end
        else if (op_accept)
        begin
            index = cache_op.addr.op.index;
        end
        else
        begin
            index = addr_q.fetch.index;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= S_IDLE;
        end
        else
        begin
            unique case (state)
                S_IDLE:
                begin
                    if (op_accept)
                    begin
                        state <= (cache_op.kind == OP_HIT_INV) ? S_OP_HIT_READ : S_OP_INDEX;
                    end
                    else if (inst_addr_ok)
                    begin
                        state <= S_LOOKUP;
                    end
                end
                S_LOOKUP:
                begin
                    if (!hit_any)
                    begin
                        state <= S_REFILL;
                    end
                    else if (!inst_addr_ok)
                    begin
                        state <= S_IDLE;
                    end
                end
                S_REFILL:
                begin
                    if (refill_done)
                    begin
                        state <= S_REREAD;
                    end
                end
                S_REREAD:      state <= S_LOOKUP;
                S_OP_HIT_READ: state <= S_OP_HIT_CLEAR;
                default:       state <= S_IDLE;
            endcase
        end
    end

    // op addresses share the holding register, the union tells them apart
    always_ff @(posedge clk)
    begin
        if (inst_addr_ok)
        begin
            addr_q <= inst_addr;
        end
        else if (op_accept)
        begin
            addr_q <= cache_op.addr;
        end
        if (refill_start)
        begin
            fill_way <= victim;
        end
        if (state == S_OP_HIT_READ)
        begin
            hit_q <= hit;
        end
    end

endmodule

//--- design/icache_top.sv
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         inst_req,
    input  icache_addr_u inst_addr,
    output logic         inst_addr_ok,
    output logic         inst_data_ok,
    output word_t        inst_rdata,
    input  logic         cache_req,
    input  cache_op_t    cache_op,
    output logic         cache_op_ok,
    output word_t        araddr,
    output logic         arvalid,
    input  logic         arready,
    input  axi_r_t       r,
    input  logic         rvalid,
    output logic         rready
);

    way_mask_t hit;
    way_t      victim;
    index_t    index;
    tag_t      lookup_tag;
    beat_t     word_sel;
    logic      tag_wr_en;
    way_t      fill_way;
    logic      inv_en;
    way_t      inv_way;
    logic      lru_touch;
    way_t      lru_touch_way;
    logic      refill_start;
    word_t     line_addr;
    logic      refill_done;
    logic      fill_en;
    beat_t     fill_beat;

    icache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .inst_req      (inst_req),
        .inst_addr     (inst_addr),
        .inst_addr_ok  (inst_addr_ok),
        .inst_data_ok  (inst_data_ok),
        .cache_req     (cache_req),
        .cache_op      (cache_op),
        .cache_op_ok   (cache_op_ok),
        .hit           (hit),
        .victim        (victim),
        .index         (index),
        .lookup_tag    (lookup_tag),
        .word_sel      (word_sel),
        .tag_wr_en     (tag_wr_en),
        .fill_way      (fill_way),
        .inv_en        (inv_en),
        .inv_way       (inv_way),
        .lru_touch     (lru_touch),
        .lru_touch_way (lru_touch_way),
        .refill_start  (refill_start),
        .line_addr     (line_addr),
        .refill_done   (refill_done)
    );

    icache_tag_array u_tag (
        .clk        (clk),
        .rst        (rst),
        .index      (index),
        .lookup_tag (lookup_tag),
        .wr_en      (tag_wr_en),
        .wr_way     (fill_way),
        .wr_tag     (lookup_tag),
        .inv_en     (inv_en),
        .inv_way    (inv_way),
        .hit        (hit)
    );

    // refill beats go straight from the R channel into the line
    icache_data_array u_data (
        .clk      (clk),
        .index    (index),
        .wr_en    (fill_en),
        .wr_way   (fill_way),
        .wr_beat  (fill_beat),
        .wr_data  (r.data),
        .hit      (hit),
        .word_sel (word_sel),
        .rdata    (inst_rdata)
    );

    icache_lru u_lru (
        .clk       (clk),
        .rst       (rst),
        .index     (index),
        .touch     (lru_touch),
        .touch_way (lru_touch_way),
        .victim    (victim)
    );

    icache_refill u_refill (
        .clk          (clk),
        .rst          (rst),
        .refill_start (refill_start),
        .line_addr    (line_addr),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .r            (r),
        .rvalid       (rvalid),
        .rready       (rready),
        .fill_en      (fill_en),
        .fill_beat    (fill_beat),
        .refill_done  (refill_done)
    );

endmodule

//--- tb/icache_chk.sv
`timescale 1ns/1ps

module icache_chk
    import icache_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  inst_addr_ok,
    input logic  inst_data_ok,
    input logic  cache_req,
    input logic  cache_op_ok,
    input word_t araddr,
    input logic  arvalid,
    input logic  arready
);

    int   pending;
    logic ar_fail   = 1'b0;
    logic data_fail = 1'b0;
    logic op_fail   = 1'b0;
    logic excl_fail = 1'b0;
    logic any_fail;

    assign any_fail = ar_fail | data_fail | op_fail | excl_fail;

    // fetches accepted but not yet answered
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pending <= 0;
        end
        else
        begin
            pending <= pending + int'(inst_addr_ok) - int'(inst_data_ok);
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
    else
    begin
        ar_fail = 1'b1;
        $error("arvalid dropped or araddr moved before arready");
    end

    data_needs_fetch: assert property (@(posedge clk) disable iff (rst)
        inst_data_ok |-> pending > 0)
    else
    begin
        data_fail = 1'b1;
        $error("inst_data_ok with no fetch outstanding");
    end

    op_ok_in_req: assert property (@(posedge clk) disable iff (rst)
        cache_op_ok |-> cache_req)
    else
    begin
        op_fail = 1'b1;
        $error("cache_op_ok while cache_req is low");
    end

    no_fetch_during_op: assert property (@(posedge clk) disable iff (rst)
        !(inst_addr_ok && cache_req))
    else
    begin
        excl_fail = 1'b1;
        $error("inst_addr_ok high together with cache_req");
    end

endmodule

//--- tb/icache_tb.sv
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
();

    // 300 random fetches, about a third missing at up to ~50 cycles each,
    // plus the directed tests, stay well below this
    localparam int MAX_CYCLES   = 20000;
    localparam int RAND_FETCHES = 300;

    logic         clk = 1'b0;
    logic         rst;
    logic         inst_req;
    icache_addr_u inst_addr;
    logic         inst_addr_ok;
    logic         inst_data_ok;
    word_t        inst_rdata;
    logic         cache_req;
    cache_op_t    cache_op;
    logic         cache_op_ok;
    word_t        araddr;
    logic         arvalid;
    logic         arready;
    axi_r_t       r;
    logic         rvalid;
    logic         rready;

    int          cycle = 0;
    logic [31:0] rng_state = 32'ha637_67d6;

    // reference tags, valid bits and recency stacks (entry 0 most recent)
    tag_t model_tag [SETS][WAYS];
    logic model_valid [SETS][WAYS];
    way_t model_lru [SETS][WAYS];

    word_t issue_q [$];
    logic  issue_miss [$];
    word_t flight_q [$];
    logic  flight_miss [$];
    int    flight_cyc [$];
    int    done_cyc [$];
    logic  saw_ar;
    word_t seen_araddr;

    icache_top UUT (
        .clk          (clk),
        .rst          (rst),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .cache_req    (cache_req),
        .cache_op     (cache_op),
        .cache_op_ok  (cache_op_ok),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .r            (r),
        .rvalid       (rvalid),
        .rready       (rready)
    );

    bind icache_top icache_chk u_chk (
        .clk          (clk),
        .rst          (rst),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .cache_req    (cache_req),
        .cache_op_ok  (cache_op_ok),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready)
    );

    always #4 clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES)
        begin
            stop_with_error($sformatf("timeout: run not finished after %0d cycles", MAX_CYCLES));
        end
    end

    always @(negedge clk)
    begin
        if (UUT.u_chk.any_fail)
        begin
            stop_with_error("a protocol assertion on the DUT ports failed");
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // each memory word holds its own address inverted
    function automatic word_t mem_word(word_t a);
        return ~{a[31:2], 2'b00};
    endfunction

    function automatic word_t make_addr(tag_t t, index_t s, int word);
        return {t, s, beat_t'(word), 2'b00};
    endfunction

    function automatic void model_touch(int set, way_t way);
        int pos;
        pos = WAYS - 1;
        for (int i = 0; i < WAYS; i++)
        begin
            if (model_lru[set][i] == way)
            begin
                pos = i;
            end
        end
        for (int i = pos; i > 0; i--)
        begin
            model_lru[set][i] = model_lru[set][i-1];
        end
        model_lru[set][0] = way;
    endfunction

    function automatic int model_way_of(word_t a);
        icache_addr_u u;
        int           found;
        u = a;
        found = -1;
        for (int w = 0; w < WAYS; w++)
        begin
            if (model_valid[int'(u.fetch.index)][w]
                && model_tag[int'(u.fetch.index)][w] == u.fetch.tag)
            begin
                found = w;
            end
        end
        return found;
    endfunction

    // returns 1 on a predicted miss and then fills the least recent way
    function automatic logic model_access(word_t a);
        icache_addr_u u;
        int           set;
        int           found;
        way_t         way;
        u = a;
        set = int'(u.fetch.index);
        found = model_way_of(a);
        way = (found < 0) ? model_lru[set][WAYS-1] : way_t'(found);
        if (found < 0)
        begin
            model_tag[set][way] = u.fetch.tag;
            model_valid[set][way] = 1'b1;
        end
        model_touch(set, way);
        return found < 0;
    endfunction

    task automatic check_value(input string name, input string what,
                               input word_t expected, input word_t actual);
        assert (expected == actual)
        else stop_with_error($sformatf("FAILED %s %s: expected %h, actual %h",
                                       name, what, expected, actual));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic queue_fetch(input word_t a);
        issue_q.push_back(a);
        issue_miss.push_back(model_access(a));
    endtask

    // keeps inst_req up while fetches are queued and checks each returned word
    task automatic run_fetches(input string name);
        word_t a;
        logic  exp_miss;
        int    lat;
        while (issue_q.size() > 0 || flight_q.size() > 0)
        begin
            inst_req = (issue_q.size() > 0);
            if (issue_q.size() > 0)
            begin
                inst_addr = issue_q[0];
            end
            @(negedge clk);
            if (arvalid && !saw_ar)
            begin
                saw_ar = 1'b1;
                seen_araddr = araddr;
            end
            if (inst_data_ok)
            begin
                assert (flight_q.size() > 0)
                else stop_with_error({name, ": inst_data_ok with no fetch accepted"});
                a = flight_q.pop_front();
                exp_miss = flight_miss.pop_front();
                lat = cycle - flight_cyc.pop_front();
                done_cyc.push_back(cycle);
                check_value(name, "rdata", mem_word(a), inst_rdata);
                check_value(name, "miss", word_t'(exp_miss), word_t'(saw_ar));
                if (exp_miss)
                begin
                    check_value(name, "araddr", {a[31:5], 5'd0}, seen_araddr);
                end
                else
                begin
                    check_value(name, "hit latency", 32'd1, word_t'(lat));
                end
                saw_ar = 1'b0;
            end
            if (inst_req && inst_addr_ok)
            begin
                flight_q.push_back(issue_q.pop_front());
                flight_miss.push_back(issue_miss.pop_front());
                flight_cyc.push_back(cycle);
            end
            @(posedge clk);
            #1;
        end
        inst_req = 1'b0;
    endtask

    task automatic run_cache_op(input string name, input cache_op_kind_e kind, input word_t a);
        int start;
        cache_req = 1'b1;
        cache_op.kind = kind;
        cache_op.addr = a;
        start = cycle;
        do
        begin
            @(negedge clk);
        end
        while (!cache_op_ok);
        check_value(name, "op latency", (kind == OP_HIT_INV) ? 32'd2 : 32'd1,
                    word_t'(cycle - start));
        @(posedge clk);
        #1;
        cache_req = 1'b0;
    endtask

    // AXI read slave with random stalls on both channels
    initial
    begin : axi_mem
        word_t base;
        arready = 1'b0;
        rvalid  = 1'b0;
        r       = '0;
        forever
        begin
            @(negedge clk);
            if (arvalid)
            begin
                @(posedge clk);
                #1;
                idle_cycles(int'(next_rand() % 32'd4));
                arready = 1'b1;
                @(negedge clk);
                base = araddr;
                @(posedge clk);
                #1;
                arready = 1'b0;
                for (int b = 0; b < LINE_WORDS; b++)
                begin
                    idle_cycles(int'(next_rand() % 32'd4));
                    rvalid = 1'b1;
                    r.data = mem_word(base + word_t'(4 * b));
                    r.last = (b == LINE_WORDS - 1);
                    do
                    begin
                        @(negedge clk);
                    end
                    while (!rready);
                    @(posedge clk);
                    #1;
                    rvalid = 1'b0;
                    r      = '0;
                end
            end
        end
    end

    initial
    begin
        int    w;
        word_t a;
        rst       = 1'b1;
        inst_req  = 1'b0;
        inst_addr = '0;
        cache_req = 1'b0;
        cache_op  = '0;
        saw_ar    = 1'b0;
        for (int s = 0; s < SETS; s++)
        begin
            for (int i = 0; i < WAYS; i++)
            begin
                model_tag[s][i]   = '0;
                model_valid[s][i] = 1'b0;
                model_lru[s][i]   = way_t'(i);
            end
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value("reset", "outputs low", 32'd0,
                    word_t'({inst_addr_ok, inst_data_ok, cache_op_ok, arvalid, rready}));
        @(posedge clk);
        #1;

        queue_fetch(32'h0000_1040);
        run_fetches("cold_miss");
        queue_fetch(32'h0000_1044);
        run_fetches("hit");
        for (int i = 2; i < LINE_WORDS; i++)
        begin
            queue_fetch(32'h0000_1040 + word_t'(4 * i));
        end
        done_cyc.delete();
        run_fetches("back_to_back");
        for (int i = 1; i < done_cyc.size(); i++)
        begin
            check_value("back_to_back", "data gap", 32'd1, word_t'(done_cyc[i] - done_cyc[i-1]));
        end

        // five tags in set 9 with re-touches before the fifth
        for (int t = 0; t < 4; t++)
        begin
            queue_fetch(make_addr(tag_t'(32'h00100 + t), 7'd9, t));
        end
        queue_fetch(make_addr(20'h00100, 7'd9, 1));
        queue_fetch(make_addr(20'h00102, 7'd9, 5));
        queue_fetch(make_addr(20'h00104, 7'd9, 0));
        for (int t = 0; t < 5; t++)
        begin
            queue_fetch(make_addr(tag_t'(32'h00100 + t), 7'd9, 7 - t));
        end
        run_fetches("lru");

        a = make_addr(20'h00104, 7'd9, 3);
        w = model_way_of(a);
        assert (w >= 0)
        else stop_with_error("index_inv: reference holds no line to invalidate");
        run_cache_op("index_inv", OP_INDEX_INV, {18'd0, way_t'(w), 7'd9, 5'd0});
        model_valid[9][w] = 1'b0;
        queue_fetch(a);
        run_fetches("index_inv_refetch");

        run_cache_op("hit_inv", OP_HIT_INV, 32'h0000_1040);
        w = model_way_of(32'h0000_1040);
        if (w >= 0)
        begin
            model_valid[2][w] = 1'b0;
        end
        queue_fetch(32'h0000_1048);
        run_fetches("hit_inv_refetch");

        // a fetch request waits while the op is in progress
        queue_fetch(32'h0000_104c);
        queue_fetch(a);
        inst_req  = 1'b1;
        inst_addr = issue_q[0];
        run_cache_op("hit_inv_absent", OP_HIT_INV, 32'h0abc_de00);
        run_fetches("hit_inv_absent_refetch");

        for (int i = 0; i < RAND_FETCHES; i++)
        begin
            queue_fetch(make_addr(tag_t'(32'h0a000 + next_rand() % 32'd6),
                                  index_t'(32'd16 + next_rand() % 32'd4),
                                  int'(next_rand() % 32'd8)));
        end
        run_fetches("random");

        // bound assertions on the last edge are polled at the next negedge
        @(negedge clk);
        #1;
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- verilog.f
design/icache_pkg.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_lru.sv
design/icache_refill.sv
design/icache_ctrl.sv
design/icache_top.sv
tb/icache_chk.sv
tb/icache_tb.sv

//--- Makefile
TOP = icache_tb

all: sim

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

build:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP)

sim: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 2>&1 | tee sim.log
	@if grep -q ">>> FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q ">>> PASS" sim.log; then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all lint build sim clean
